// ==== dv/data_mem_tb.sv ====
// ----------------------------------------------------------------------
// Data memory testbench
// Table of loads and stores with a byte-level reference model,
// LFSR-driven response back-pressure and a cycle limit
// ----------------------------------------------------------------------
`default_nettype none

module data_mem_tb
  import mem_pkg::*;
();

  localparam int          MEM_BYTES    = 4096;
  localparam logic [31:0] BASE_ADDR    = 32'h0100_0000;
  localparam int          WAIT_CYCLES  = 2;
  localparam int          CLK_PERIOD   = 40;
  localparam int          RESET_CYCLES = 10;
  localparam int          DRIVE_DLY    = 2;
  // Longest run of stalled response cycles
  localparam int          MAX_STALL    = 4;

  // One table row
  typedef struct packed {
    logic        is_store;
    logic [2:0]  funct3;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        use_model;
    logic [31:0] exp_rdata;
  } vec_t;

  logic     clk;
  logic     rst_i;
  logic     req_valid_i;
  mem_req_t req_i;
  logic     req_ready_o;
  logic     rsp_valid_o;
  mem_rsp_t rsp_o;
  logic     rsp_ready_i;

  vec_t       rows[$];
  string      names[$];
  logic [7:0] model_mem [MEM_BYTES];
  logic [7:0] lfsr;
  int         errors;
  int         tests_failed;
  int         cycle_count;
  int         cycle_limit;

  data_mem_top #(
    .MEM_BYTES   (MEM_BYTES),
    .BASE_ADDR   (BASE_ADDR),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_dut (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .rsp_ready_i (rsp_ready_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Hang guard
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Timeout: no end of run within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Reference model and random source
  // ----------------------------------------------------------------------

  // Galois form, taps for x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 8'hB8;
    end
    return s >> 1;
  endfunction

  // Base region slides to zero, each byte lane wraps in the window
  function automatic int model_index(input logic [31:0] addr, input int k);
    logic [31:0] mapped;
    mapped = (addr >= BASE_ADDR) ? addr - BASE_ADDR : addr;
    return int'((mapped + 32'(k)) & 32'(MEM_BYTES - 1));
  endfunction

  function automatic void model_store(input logic [31:0] addr, input logic [2:0] f3,
                                      input logic [31:0] wdata);
    int n;
    // Raw address zero drops the store
    if (addr == 32'h0) begin
      return;
    end
    case (f3)
      SB:      n = 1;
      SH:      n = 2;
      default: n = 4;
    endcase
    for (int k = 0; k < n; k++) begin
      model_mem[model_index(addr, k)] = wdata[8*k +: 8];
    end
  endfunction

  function automatic logic [31:0] model_load(input logic [31:0] addr, input logic [2:0] f3);
    logic [31:0] w;
    for (int k = 0; k < 4; k++) begin
      w[8*k +: 8] = model_mem[model_index(addr, k)];
    end
    case (f3)
      LB:      return {{24{w[7]}}, w[7:0]};
      LBU:     return {24'h0, w[7:0]};
      LH:      return {{16{w[15]}}, w[15:0]};
      LHU:     return {16'h0, w[15:0]};
      default: return w;
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------------------

  function automatic void add_row(input string name, input logic st, input logic [2:0] f3,
                                  input logic [31:0] addr, input logic [31:0] wdata,
                                  input logic use_model, input logic [31:0] exp_rdata);
    rows.push_back({st, f3, addr, wdata, use_model, exp_rdata});
    names.push_back(name);
  endfunction

  function automatic void build_table();
    // Word readback at every offset
    add_row("sw_word",       1'b1, SW,  32'h100, 32'h80F1_7E92, 1'b0, 32'h0);
    add_row("lw_word",       1'b0, LW,  32'h100, 32'h0, 1'b0, 32'h80F1_7E92);
    add_row("lb_off0",       1'b0, LB,  32'h100, 32'h0, 1'b0, 32'hFFFF_FF92);
    add_row("lbu_off0",      1'b0, LBU, 32'h100, 32'h0, 1'b0, 32'h0000_0092);
    add_row("lb_off1",       1'b0, LB,  32'h101, 32'h0, 1'b0, 32'h0000_007E);
    add_row("lbu_off2",      1'b0, LBU, 32'h102, 32'h0, 1'b0, 32'h0000_00F1);
    add_row("lb_off3",       1'b0, LB,  32'h103, 32'h0, 1'b0, 32'hFFFF_FF80);
    add_row("lh_off0",       1'b0, LH,  32'h100, 32'h0, 1'b0, 32'h0000_7E92);
    add_row("lh_off1",       1'b0, LH,  32'h101, 32'h0, 1'b0, 32'hFFFF_F17E);
    add_row("lh_off2",       1'b0, LH,  32'h102, 32'h0, 1'b0, 32'hFFFF_80F1);
    add_row("lhu_off2",      1'b0, LHU, 32'h102, 32'h0, 1'b0, 32'h0000_80F1);
    add_row("lhu_off3",      1'b0, LHU, 32'h103, 32'h0, 1'b0, 32'h0000_0080);
    // Sub-word stores keep their neighbours
    add_row("sb_lane1",      1'b1, SB,  32'h101, 32'hFFFF_FF3C, 1'b0, 32'h0);
    add_row("lw_after_sb",   1'b0, LW,  32'h100, 32'h0, 1'b0, 32'h80F1_3C92);
    add_row("sh_upper",      1'b1, SH,  32'h102, 32'h1234_BEEF, 1'b0, 32'h0);
    add_row("lw_after_sh",   1'b0, LW,  32'h100, 32'h0, 1'b0, 32'hBEEF_3C92);
    add_row("lw_neighbour",  1'b0, LW,  32'h104, 32'h0, 1'b0, 32'h0);
    // Base mapping
    add_row("sw_based",      1'b1, SW,  BASE_ADDR + 32'h200, 32'h0BAD_CAFE, 1'b0, 32'h0);
    add_row("lw_plain",      1'b0, LW,  32'h200, 32'h0, 1'b0, 32'h0BAD_CAFE);
    add_row("lbu_based",     1'b0, LBU, BASE_ADDR + 32'h203, 32'h0, 1'b0, 32'h0000_000B);
    // Address zero swallows the store
    add_row("sw_zero",       1'b1, SW,  32'h0, 32'hDEAD_BEEF, 1'b0, 32'h0);
    add_row("lw_zero",       1'b0, LW,  32'h0, 32'h0, 1'b0, 32'h0);
    // Window end wrap
    add_row("sw_wrap",       1'b1, SW,  32'hFFE, 32'h4433_2211, 1'b0, 32'h0);
    add_row("lw_wrap",       1'b0, LW,  32'hFFE, 32'h0, 1'b0, 32'h4433_2211);
    add_row("lhu_wrapped",   1'b0, LHU, 32'h0, 32'h0, 1'b0, 32'h0000_4433);
    add_row("lw_wrap_based", 1'b0, LW,  BASE_ADDR + 32'hFFE, 32'h0, 1'b1, 32'h0);
    // Expected data from the model
    add_row("sh_model",      1'b1, SH,  BASE_ADDR + 32'h7FF, 32'h0000_A55A, 1'b0, 32'h0);
    add_row("lw_model",      1'b0, LW,  32'h7FE, 32'h0, 1'b1, 32'h0);
    add_row("lh_model",      1'b0, LH,  32'h7FF, 32'h0, 1'b1, 32'h0);
    add_row("lb_model",      1'b0, LB,  BASE_ADDR + 32'h800, 32'h0, 1'b1, 32'h0);
  endfunction

  // ----------------------------------------------------------------------
  // One request and its response
  // ----------------------------------------------------------------------

  task automatic run_row(input int i);
    vec_t        r;
    logic [31:0] exp;
    mem_rsp_t    held;
    int          wait_n;
    int          stall_n;
    int          errs_before;
    logic        taken;
    r = rows[i];
    errs_before = errors;
    // Expected value before the model sees a store
    if (r.is_store) begin
      exp = 32'h0;
      model_store(r.addr, r.funct3, r.wdata);
    end else if (r.use_model) begin
      exp = model_load(r.addr, r.funct3);
    end else begin
      exp = r.exp_rdata;
    end
    req_valid_i = 1'b1;
    req_i = {r.is_store, r.funct3, r.addr, r.wdata};
    while (!req_ready_o) begin
      @(posedge clk);
      #DRIVE_DLY;
    end
    // Accepting edge
    @(posedge clk);
    #DRIVE_DLY;
    req_valid_i = 1'b0;
    req_i = '0;
    wait_n = 1;
    while (!rsp_valid_o) begin
      assert (!req_ready_o) else begin
        $display("%s: req_ready_o high during the access", names[i]);
        errors++;
      end
      @(posedge clk);
      #DRIVE_DLY;
      wait_n++;
    end
    assert (wait_n == WAIT_CYCLES + 1) else begin
      $display("%s: response %0d cycles after acceptance, wanted %0d",
               names[i], wait_n, WAIT_CYCLES + 1);
      errors++;
    end
    held = rsp_o;
    assert (held.is_store === r.is_store) else begin
      $display("FAILED %s: is_store expected %b actual %b", names[i], r.is_store,
               held.is_store);
      errors++;
    end
    assert (held.rdata === exp) else begin
      $display("FAILED %s: expected %h actual %h", names[i], exp, held.rdata);
      errors++;
    end
    // Random back-pressure, capped at MAX_STALL
    stall_n = 0;
    taken = 1'b0;
    while (!taken) begin
      if (stall_n >= MAX_STALL) begin
        rsp_ready_i = 1'b1;
      end else begin
        lfsr = lfsr_step(lfsr);
        rsp_ready_i = lfsr[0];
      end
      taken = rsp_ready_i;
      @(posedge clk);
      #DRIVE_DLY;
      if (!taken) begin
        stall_n++;
        assert (rsp_valid_o && !req_ready_o) else begin
          $display("%s: handshake lines moved during a stall", names[i]);
          errors++;
        end
        assert (rsp_o === held) else begin
          $display("%s: response word changed during a stall", names[i]);
          errors++;
        end
      end
    end
    rsp_ready_i = 1'b0;
    assert (!rsp_valid_o && req_ready_o) else begin
      $display("%s: DUT not back in idle after the response", names[i]);
      errors++;
    end
    if (errors != errs_before) begin
      tests_failed++;
    end
    $display("test %s: %s, %0d stall cycles", names[i],
             (errors == errs_before) ? "ok" : "bad", stall_n);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    rst_i = 1'b1;
    req_valid_i = 1'b0;
    req_i = '0;
    rsp_ready_i = 1'b0;
    lfsr = 8'd35;
    errors = 0;
    tests_failed = 0;
    cycle_count = 0;
    for (int a = 0; a < MEM_BYTES; a++) begin
      model_mem[a] = 8'h00;
    end
    build_table();
    // Accept, wait, worst stall and take per row
    cycle_limit = rows.size() * (WAIT_CYCLES + 1 + MAX_STALL + 2) + RESET_CYCLES + 4;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_i = 1'b0;
    assert (req_ready_o && !rsp_valid_o) else begin
      $display("Handshake outputs wrong after reset");
      errors++;
    end
    foreach (rows[i]) begin
      run_row(i);
    end
    $display("%0d tests run, %0d tests failed, %0d check errors",
             rows.size(), tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : data_mem_tb

`default_nettype wire

// ==== files.f ====
logic/mem_pkg.sv
logic/byte_memory.sv
logic/wait_timer.sv
logic/access_fsm.sv
logic/load_extend.sv
logic/data_mem_top.sv
dv/data_mem_tb.sv

// ==== logic/access_fsm.sv ====
// ----------------------------------------------------------------------
// Access sequencer
// Accepts one request, waits out the array, fires the access and
// holds the response until the requester takes it
// ----------------------------------------------------------------------
`default_nettype none

module access_fsm
  import mem_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_i,
  // Request channel
  input  wire logic     req_valid_i,
  input  wire mem_req_t req_i,
  output logic          req_ready_o,
  // Response channel handshake
  input  wire logic     rsp_ready_i,
  output logic          rsp_valid_o,
  // Timer
  input  wire logic     done_i,
  output logic          start_o,
  // Array and response register
  output logic          wr_en_o,
  output logic          capture_o,
  output mem_req_t      acc_o
);

  access_state_e state_q;
  access_state_e state_d;
  mem_req_t      acc_q;

  logic accept;
  logic rsp_taken;
  logic last_wait;

  // ----------------------------------------------------------------------
  // Handshakes
  // ----------------------------------------------------------------------

  assign req_ready_o = (state_q == IDLE);
  assign rsp_valid_o = (state_q == RESP);

  assign accept    = req_valid_i && req_ready_o;
  assign rsp_taken = rsp_valid_o && rsp_ready_i;
  assign last_wait = (state_q == WAIT) && done_i;

  // ----------------------------------------------------------------------
  // State machine
  // ----------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (accept)    state_d = WAIT;
      WAIT:    if (done_i)    state_d = RESP;
      RESP:    if (rsp_taken) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // Timer kick goes out with the accepting edge
  assign start_o = accept;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Accepted request, held for the whole access
  always_ff @(posedge clk) begin
    if (accept) begin
      acc_q <= req_i;
    end
  end

  assign acc_o = acc_q;

  // Write and capture share the last wait edge
  // Capture sees the bytes before the store lands
  assign wr_en_o   = last_wait && acc_q.is_store;
  assign capture_o = last_wait;

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // Timer may only finish inside an access
  a_done_in_wait : assert property (@(posedge clk) disable iff (rst_i)
    done_i |-> (state_q == WAIT))
    else $error("wait timer finished outside an access");

  // Response must wait for the requester
  a_rsp_held : assert property (@(posedge clk) disable iff (rst_i)
    (rsp_valid_o && !rsp_ready_i) |=> rsp_valid_o)
    else $error("response dropped before it was taken");

endmodule : access_fsm

`default_nettype wire

// ==== logic/byte_memory.sv ====
// ----------------------------------------------------------------------
// Byte array of the data memory
// Maps addresses into the window, writes sized byte lanes and
// returns four bytes little-endian without a clock
// ----------------------------------------------------------------------
`default_nettype none

module byte_memory
  import mem_pkg::*;
#(
  parameter int          MEM_BYTES = 4096,
  parameter logic [31:0] BASE_ADDR = 32'h0100_0000
) (
  input  wire logic        clk,
  input  wire logic        rst_i,
  input  wire mem_req_t    req_i,
  input  wire logic        wr_en_i,
  output logic      [31:0] rd_bytes_o
);

  // Index width for the window
  localparam int AW = $clog2(MEM_BYTES);

  logic [7:0] mem [MEM_BYTES];

  logic [31:0]   addr_mapped;
  logic [AW-1:0] lane_idx [4];
  logic [3:0]    lane_we;
  logic          wr_fire;

  // ----------------------------------------------------------------------
  // Address mapping
  // ----------------------------------------------------------------------

  // Region at BASE_ADDR slides down to zero
  assign addr_mapped = (req_i.addr >= BASE_ADDR) ? (req_i.addr - BASE_ADDR) : req_i.addr;

  // Low bits give the window offset
  // Each lane index wraps by itself at the window end
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      lane_idx[k] = addr_mapped[AW-1:0] + AW'(k);
    end
  end

  // ----------------------------------------------------------------------
  // Array contents
  // ----------------------------------------------------------------------

  // Start all zero
  initial begin
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[i] = 8'h00;
    end
  end

  // Lane enables from the store size
  always_comb begin
    case (req_i.funct3.st)
      SB:      lane_we = 4'b0001;
      SH:      lane_we = 4'b0011;
      default: lane_we = 4'b1111;
    endcase
  end

  // Address zero swallows stores
  assign wr_fire = wr_en_i && req_i.is_store && !rst_i && (req_i.addr != 32'h0);

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int k = 0; k < 4; k++) begin
        if (lane_we[k]) begin
          mem[lane_idx[k]] <= req_i.wdata[8*k +: 8];
        end
      end
    end
  end

  // Byte 0 sits in the low lane
  assign rd_bytes_o = {mem[lane_idx[3]], mem[lane_idx[2]],
                       mem[lane_idx[1]], mem[lane_idx[0]]};

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // Window wrap relies on plain index truncation
  a_mem_pow2 : assert property (@(posedge clk) disable iff (rst_i)
    (MEM_BYTES > 0) && ((MEM_BYTES & (MEM_BYTES - 1)) == 0))
    else $error("MEM_BYTES %0d is not a power of two", MEM_BYTES);

endmodule : byte_memory

`default_nettype wire

// ==== logic/data_mem_top.sv ====
// ----------------------------------------------------------------------
// Data memory top level
// Request and response channels around the sequencer, the wait
// timer, the byte array and the response register
// ----------------------------------------------------------------------
`default_nettype none

module data_mem_top
  import mem_pkg::*;
#(
  parameter int          MEM_BYTES   = 4096,
  parameter logic [31:0] BASE_ADDR   = 32'h0100_0000,
  parameter int          WAIT_CYCLES = 2
) (
  input  wire logic     clk,
  input  wire logic     rst_i,
  // Request channel
  input  wire logic     req_valid_i,
  input  wire mem_req_t req_i,
  output logic          req_ready_o,
  // Response channel
  output logic          rsp_valid_o,
  output mem_rsp_t      rsp_o,
  input  wire logic     rsp_ready_i
);

  // Internal wiring
  mem_req_t    acc;
  logic        start;
  logic        done;
  logic        wr_en;
  logic        capture;
  logic [31:0] rd_bytes;

  access_fsm u_access_fsm (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_valid_o (rsp_valid_o),
    .done_i      (done),
    .start_o     (start),
    .wr_en_o     (wr_en),
    .capture_o   (capture),
    .acc_o       (acc)
  );

  wait_timer #(.WAIT_CYCLES(WAIT_CYCLES)) u_wait_timer (
    .clk     (clk),
    .rst_i   (rst_i),
    .start_i (start),
    .done_o  (done)
  );

  byte_memory #(.MEM_BYTES(MEM_BYTES), .BASE_ADDR(BASE_ADDR)) u_byte_memory (
    .clk        (clk),
    .rst_i      (rst_i),
    .req_i      (acc),
    .wr_en_i    (wr_en),
    .rd_bytes_o (rd_bytes)
  );

  load_extend u_load_extend (
    .clk        (clk),
    .rst_i      (rst_i),
    .capture_i  (capture),
    .acc_i      (acc),
    .rd_bytes_i (rd_bytes),
    .rsp_o      (rsp_o)
  );

endmodule : data_mem_top

`default_nettype wire

// ==== logic/load_extend.sv ====
// ----------------------------------------------------------------------
// Response register
// Cuts loads to size with sign or zero fill and holds the
// response word under back-pressure
// ----------------------------------------------------------------------
`default_nettype none

module load_extend
  import mem_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_i,
  input  wire logic        capture_i,
  input  wire mem_req_t    acc_i,
  input  wire logic [31:0] rd_bytes_i,
  output mem_rsp_t         rsp_o
);

  logic [7:0]  byte0;
  logic [15:0] half0;
  logic [31:0] load_data;
  mem_rsp_t    rsp_d;

  assign byte0 = rd_bytes_i[7:0];
  assign half0 = rd_bytes_i[15:0];

  // ----------------------------------------------------------------------
  // Load sizing
  // ----------------------------------------------------------------------

  always_comb begin
    case (acc_i.funct3.ld)
      LB:      load_data = {{24{byte0[7]}}, byte0};
      LBU:     load_data = {24'h0, byte0};
      LH:      load_data = {{16{half0[15]}}, half0};
      LHU:     load_data = {16'h0, half0};
      // LW and unknown codes
      default: load_data = rd_bytes_i;
    endcase
  end

  // Stores answer with empty data
  assign rsp_d.is_store = acc_i.is_store;
  assign rsp_d.rdata    = acc_i.is_store ? 32'h0 : load_data;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rsp_o <= '0;
    end else if (capture_i) begin
      rsp_o <= rsp_d;
    end
  end

  // Only a capture may move the held response
  a_rsp_stable : assert property (@(posedge clk) disable iff (rst_i)
    !capture_i |=> $stable(rsp_o))
    else $error("response word changed without a capture");

endmodule : load_extend

`default_nettype wire

// ==== logic/mem_pkg.sv ====
// ----------------------------------------------------------------------
// Data memory shared types
// Load and store size codes, the funct3 view union and the
// request and response words of the memory channels
// ----------------------------------------------------------------------
`default_nettype none

package mem_pkg;

  // ----------------------------------------------------------------------
  // funct3 encodings
  // ----------------------------------------------------------------------

  // Load kinds as RISC-V encodes them
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LH  = 3'd1,
    LW  = 3'd2,
    LBU = 3'd4,
    LHU = 3'd5
  } funct3_load_e;

  // Store kinds
  typedef enum logic [2:0] {
    SB = 3'd0,
    SH = 3'd1,
    SW = 3'd2
  } funct3_store_e;

  // Same three bits, read as load or store kind
  typedef union packed {
    funct3_load_e  ld;
    funct3_store_e st;
  } funct3_u;

  // ----------------------------------------------------------------------
  // Channel words
  // ----------------------------------------------------------------------

  // Request from the core, 68 bits
  typedef struct packed {
    logic        is_store;
    funct3_u     funct3;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  // Response to the core, 33 bits
  // rdata is zero on a store acknowledge
  typedef struct packed {
    logic        is_store;
    logic [31:0] rdata;
  } mem_rsp_t;

  // Access sequencer states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    WAIT = 2'd1,
    RESP = 2'd2
  } access_state_e;

endpackage : mem_pkg

`default_nettype wire

// ==== logic/wait_timer.sv ====
// ----------------------------------------------------------------------
// Wait state timer
// Counts the slow-array cycles of one access and flags the last one
// ----------------------------------------------------------------------
`default_nettype none

module wait_timer #(
  parameter int WAIT_CYCLES = 2
) (
  input  wire logic clk,
  input  wire logic rst_i,
  input  wire logic start_i,
  output logic      done_o
);

  localparam int CW = $clog2(WAIT_CYCLES + 1);

  // Zero means idle
  logic [CW-1:0] count_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (start_i) begin
      count_q <= CW'(WAIT_CYCLES);
    end else if (count_q != '0) begin
      count_q <= count_q - CW'(1);
    end
  end

  // Last wait cycle
  assign done_o = (count_q == CW'(1));

  // One access at a time
  // The sequencer must not restart a running count
  a_no_restart : assert property (@(posedge clk) disable iff (rst_i)
    start_i |-> (count_q == '0))
    else $error("wait_timer restarted while counting");

endmodule : wait_timer

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Compile the data memory testbench with Verilator and run it.
# Exit status is zero only when the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module data_mem_tb \
  -f files.f \
  -Mdir obj_dir \
  -o data_mem_sim
if [ $? -ne 0 ]; then
  echo "run.sh: Verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/data_mem_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "run.sh: simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Finished with no errors"; then
  exit 0
fi
echo "run.sh: pass message not found"
exit 1
